// File: source/fetch_pkg.sv
package fetch_pkg;

	// instruction slots per fetch group
	localparam int FETCH_SIZE = 2;

	// slot index width of at least one bit
	localparam int SLOT_W = (FETCH_SIZE > 1) ? $clog2(FETCH_SIZE) : 1;

	// side-band word carried alongside each group
	localparam int ATTACHED_W = 32;

	// primary opcode values, bits 31:26 of the instruction
	localparam logic [5:0] OP_SPECIAL   = 6'd0;
	localparam logic [5:0] OP_J         = 6'd2;
	localparam logic [5:0] OP_JAL       = 6'd3;
	localparam logic [5:0] OP_BRANCH_LO = 6'd4;
	localparam logic [5:0] OP_BRANCH_HI = 6'd7;
	localparam logic [5:0] OP_IMM_LO    = 6'd8;
	localparam logic [5:0] OP_IMM_HI    = 6'd15;
	localparam logic [5:0] OP_LW        = 6'd35;
	localparam logic [5:0] OP_SW        = 6'd43;

	typedef logic [31:0]             addr_t;
	typedef logic [31:0]             word_t;
	typedef logic [FETCH_SIZE-1:0]   slot_mask_t;
	typedef logic [SLOT_W-1:0]       slot_idx_t;
	typedef logic [ATTACHED_W-1:0]   attached_t;
	typedef logic [4:0]              reg_idx_t;
	typedef logic [15:0]             imm_t;
	typedef logic [5:0]              opcode_t;

	// decode class of one instruction with ALU_REG as the reset value
	typedef enum logic [2:0] {
		ALU_REG = 3'd0,
		ALU_IMM = 3'd1,
		LOAD    = 3'd2,
		STORE   = 3'd3,
		BRANCH  = 3'd4,
		JUMP    = 3'd5,
		ILLEGAL = 3'd6
	} inst_class_e;

	// bus controller states
	typedef enum logic [1:0] {
		IDLE = 2'd0,
		ADDR = 2'd1,
		DATA = 2'd2
	} ctrl_state_e;

endpackage

// File: source/slot_decoder.sv
`timescale 1ns/1ps

module slot_decoder (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    load_i,
	input  fetch_pkg::word_t        inst_i,
	output fetch_pkg::inst_class_e  class_o,
	output fetch_pkg::reg_idx_t     rs_o,
	output fetch_pkg::reg_idx_t     rt_o,
	output fetch_pkg::reg_idx_t     rd_o,
	output fetch_pkg::imm_t         imm_o
);

	fetch_pkg::opcode_t     opcode;
	fetch_pkg::inst_class_e class_d;

	assign opcode = inst_i[31:26];

	// class from the primary opcode only
	always_comb begin
		case (opcode) inside
			fetch_pkg::OP_SPECIAL: begin
				class_d = fetch_pkg::ALU_REG;
			end
			[fetch_pkg::OP_IMM_LO:fetch_pkg::OP_IMM_HI]: begin
				class_d = fetch_pkg::ALU_IMM;
			end
			fetch_pkg::OP_LW: begin
				class_d = fetch_pkg::LOAD;
			end
			fetch_pkg::OP_SW: begin
				class_d = fetch_pkg::STORE;
			end
			[fetch_pkg::OP_BRANCH_LO:fetch_pkg::OP_BRANCH_HI]: begin
				class_d = fetch_pkg::BRANCH;
			end
			fetch_pkg::OP_J, fetch_pkg::OP_JAL: begin
				class_d = fetch_pkg::JUMP;
			end
			default: begin
				class_d = fetch_pkg::ILLEGAL;
			end
		endcase
	end

	// fields are sliced the same way for every class
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			class_o <= fetch_pkg::ALU_REG;
			rs_o    <= '0;
			rt_o    <= '0;
			rd_o    <= '0;
			imm_o   <= '0;
		end else if (load_i) begin
			class_o <= class_d;
			rs_o    <= inst_i[25:21];
			rt_o    <= inst_i[20:16];
			rd_o    <= inst_i[15:11];
			imm_o   <= inst_i[15:0];
		end
	end

endmodule

// File: source/fetch_pipe.sv
`timescale 1ns/1ps

module fetch_pipe (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   stall_i,
	input  logic                   clr_i,
	input  logic                   busy_i,
	input  fetch_pkg::addr_t       vpc_i,
	input  fetch_pkg::addr_t       ppc_i,
	input  fetch_pkg::slot_mask_t  valid_i,
	input  fetch_pkg::attached_t   attached_i,
	output fetch_pkg::addr_t       vpc_o,
	output fetch_pkg::addr_t       ppc_o,
	output fetch_pkg::slot_mask_t  valid_o,
	output fetch_pkg::attached_t   attached_o,
	output logic                   advance_o,
	output fetch_pkg::slot_mask_t  load_mask_o
);

	fetch_pkg::addr_t      vpc_s1, vpc_s2;
	fetch_pkg::addr_t      ppc_s1, ppc_s2;
	fetch_pkg::slot_mask_t valid_s1, valid_s2;
	fetch_pkg::attached_t  attached_s1, attached_s2;

	// whole pipe moves only when nobody holds it
	assign advance_o = !stall_i && !busy_i;

	// stage 1 takes the incoming group
	always_ff @(posedge clk) begin
		if (!rst_n || clr_i) begin
			vpc_s1      <= '0;
			ppc_s1      <= '0;
			valid_s1    <= '0;
			attached_s1 <= '0;
		end else if (advance_o) begin
			vpc_s1      <= vpc_i;
			ppc_s1      <= ppc_i;
			valid_s1    <= valid_i;
			attached_s1 <= attached_i;
		end
	end

	// stage 2 holds the group being fetched
	always_ff @(posedge clk) begin
		if (!rst_n || clr_i) begin
			vpc_s2      <= '0;
			ppc_s2      <= '0;
			valid_s2    <= '0;
			attached_s2 <= '0;
		end else if (advance_o) begin
			vpc_s2      <= vpc_s1;
			ppc_s2      <= ppc_s1;
			valid_s2    <= valid_s1;
			attached_s2 <= attached_s1;
		end
	end

	// controller loads its pending slots from here on the advance edge
	assign load_mask_o = valid_s1;

	// group only shows once every slot decoder has its word
	assign valid_o = valid_s2 & {fetch_pkg::FETCH_SIZE{!busy_i}};

	assign vpc_o      = vpc_s2;
	assign ppc_o      = ppc_s2;
	assign attached_o = attached_s2;

endmodule

// File: source/fetch_bus_ctrl.sv
`timescale 1ns/1ps

module fetch_bus_ctrl (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   clr_i,
	input  logic                   advance_i,
	input  fetch_pkg::slot_mask_t  load_mask_i,
	input  fetch_pkg::addr_t       base_i,
	output logic                   busy_o,
	output logic                   bus_valid_o,
	output fetch_pkg::addr_t       bus_addr_o,
	output logic                   bus_data_ok_o,
	input  logic                   bus_ready_i,
	input  fetch_pkg::word_t       bus_rdata_i,
	input  logic                   bus_data_ok_i,
	output fetch_pkg::slot_mask_t  slot_load_o,
	output fetch_pkg::word_t       rdata_o
);

	fetch_pkg::ctrl_state_e state_q, state_d;
	fetch_pkg::slot_mask_t  pending_q;
	fetch_pkg::slot_idx_t   sel_slot;
	fetch_pkg::slot_idx_t   slot_q;
	fetch_pkg::addr_t       addr_q;
	logic                   start;
	logic                   xfer_done;
	logic                   orphan_q;
	logic                   capture;

	assign busy_o = |pending_q;

	// lowest pending slot wins
	always_comb begin
		sel_slot = '0;
		for (int i = fetch_pkg::FETCH_SIZE - 1; i >= 0; i--) begin
			if (pending_q[i]) begin
				sel_slot = fetch_pkg::slot_idx_t'(i);
			end
		end
	end

	assign start     = (state_q == fetch_pkg::IDLE) && busy_o && !clr_i;
	assign xfer_done = bus_data_ok_o && bus_data_ok_i;

	// a cleared word still finishes on the bus but never reaches a decoder
	assign capture = xfer_done && !orphan_q && !clr_i;

	always_comb begin
		state_d = state_q;
		case (state_q)
			fetch_pkg::IDLE: begin
				if (start) begin
					state_d = fetch_pkg::ADDR;
				end
			end
			fetch_pkg::ADDR: begin
				if (bus_ready_i) begin
					state_d = fetch_pkg::DATA;
				end
			end
			fetch_pkg::DATA: begin
				if (xfer_done) begin
					state_d = fetch_pkg::IDLE;
				end
			end
			default: begin
				state_d = fetch_pkg::IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state_q <= fetch_pkg::IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// word address and slot frozen for the whole transfer
	always_ff @(posedge clk) begin
		if (start) begin
			slot_q <= sel_slot;
			addr_q <= {base_i[31:fetch_pkg::SLOT_W+2], sel_slot, 2'b00};
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pending_q <= '0;
		end else if (clr_i) begin
			pending_q <= '0;
		end else if (advance_i) begin
			pending_q <= load_mask_i;
		end else if (capture) begin
			pending_q[slot_q] <= 1'b0;
		end
	end

	// marks a transfer in flight whose group was cleared
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			orphan_q <= 1'b0;
		end else if (xfer_done) begin
			orphan_q <= 1'b0;
		end else if (clr_i && state_q != fetch_pkg::IDLE) begin
			orphan_q <= 1'b1;
		end
	end

	assign bus_valid_o   = (state_q == fetch_pkg::ADDR);
	assign bus_data_ok_o = (state_q == fetch_pkg::DATA);
	assign bus_addr_o    = addr_q;

	assign slot_load_o = capture ? fetch_pkg::slot_mask_t'(1) << slot_q : '0;
	assign rdata_o     = bus_rdata_i;

endmodule

// File: source/fetch_top.sv
`timescale 1ns/1ps

module fetch_top (
	input  logic                    clk,
	input  logic                    rst_n,
	input  fetch_pkg::addr_t        vpc_i,
	input  fetch_pkg::addr_t        ppc_i,
	input  fetch_pkg::slot_mask_t   valid_i,
	input  fetch_pkg::attached_t    attached_i,
	input  logic                    stall_i,
	input  logic                    clr_i,
	output logic                    busy_o,
	output fetch_pkg::addr_t        vpc_o,
	output fetch_pkg::addr_t        ppc_o,
	output fetch_pkg::slot_mask_t   valid_o,
	output fetch_pkg::attached_t    attached_o,
	output fetch_pkg::inst_class_e  class_o [fetch_pkg::FETCH_SIZE],
	output fetch_pkg::reg_idx_t     rs_o [fetch_pkg::FETCH_SIZE],
	output fetch_pkg::reg_idx_t     rt_o [fetch_pkg::FETCH_SIZE],
	output fetch_pkg::reg_idx_t     rd_o [fetch_pkg::FETCH_SIZE],
	output fetch_pkg::imm_t         imm_o [fetch_pkg::FETCH_SIZE],
	output logic                    bus_valid_o,
	output fetch_pkg::addr_t        bus_addr_o,
	output logic                    bus_data_ok_o,
	input  logic                    bus_ready_i,
	input  fetch_pkg::word_t        bus_rdata_i,
	input  logic                    bus_data_ok_i
);

	logic                  advance;
	fetch_pkg::slot_mask_t load_mask;
	fetch_pkg::slot_mask_t slot_load;
	fetch_pkg::word_t      rdata;

	fetch_pipe fetch_pipe_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.stall_i     (stall_i),
		.clr_i       (clr_i),
		.busy_i      (busy_o),
		.vpc_i       (vpc_i),
		.ppc_i       (ppc_i),
		.valid_i     (valid_i),
		.attached_i  (attached_i),
		.vpc_o       (vpc_o),
		.ppc_o       (ppc_o),
		.valid_o     (valid_o),
		.attached_o  (attached_o),
		.advance_o   (advance),
		.load_mask_o (load_mask)
	);

	// stage-2 physical PC is the base for every word address
	fetch_bus_ctrl fetch_bus_ctrl_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.clr_i         (clr_i),
		.advance_i     (advance),
		.load_mask_i   (load_mask),
		.base_i        (ppc_o),
		.busy_o        (busy_o),
		.bus_valid_o   (bus_valid_o),
		.bus_addr_o    (bus_addr_o),
		.bus_data_ok_o (bus_data_ok_o),
		.bus_ready_i   (bus_ready_i),
		.bus_rdata_i   (bus_rdata_i),
		.bus_data_ok_i (bus_data_ok_i),
		.slot_load_o   (slot_load),
		.rdata_o       (rdata)
	);

	for (genvar i = 0; i < fetch_pkg::FETCH_SIZE; i++) begin : g_slot
		slot_decoder slot_decoder_i (
			.clk     (clk),
			.rst_n   (rst_n),
			.load_i  (slot_load[i]),
			.inst_i  (rdata),
			.class_o (class_o[i]),
			.rs_o    (rs_o[i]),
			.rt_o    (rt_o[i]),
			.rd_o    (rd_o[i]),
			.imm_o   (imm_o[i])
		);
	end

endmodule

// File: test/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int HALF_PERIOD  = 10,
	parameter int RESET_CYCLES = 8
) (
	output logic clk_o,
	output logic rst_n_o
);

	initial begin
		clk_o = 1'b0;
		forever #(HALF_PERIOD) clk_o = ~clk_o;
	end

	// reset held low over the first rising edges
	initial begin
		rst_n_o = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_o);
		rst_n_o <= 1'b1;
	end

endmodule

// File: test/tb_mem_responder.sv
`timescale 1ns/1ps

module tb_mem_responder #(
	parameter int          MEM_WORDS = 64,
	parameter logic [31:0] SEED      = 32'h2377
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              bus_valid_i,
	input  fetch_pkg::addr_t  bus_addr_i,
	input  logic              bus_data_ok_i,
	output logic              bus_ready_o,
	output fetch_pkg::word_t  bus_rdata_o,
	output logic              bus_data_ok_o
);

	// opcode picked by the low three word-index bits
	localparam logic [47:0] OP_LIST = {6'd14, 6'd50, 6'd3, 6'd6, 6'd43, 6'd35, 6'd9, 6'd0};

	fetch_pkg::word_t mem [MEM_WORDS];
	fetch_pkg::addr_t rd_addr;
	logic             have_data;
	int unsigned      addr_wait;
	int unsigned      data_wait;
	bit               seeded;

	function automatic fetch_pkg::word_t fill_word(input fetch_pkg::addr_t a);
		logic [31:0] mix;
		mix = (a ^ 32'h1f3a5c27) * 32'd40503;
		return {OP_LIST[a[4:2] * 6 +: 6], mix[25:0]};
	endfunction

	initial begin
		for (int i = 0; i < MEM_WORDS; i++) begin
			mem[i] = fill_word(fetch_pkg::addr_t'(i * 4));
		end
		rd_addr   = '0;
		have_data = 1'b0;
		addr_wait = 0;
		data_wait = 0;
	end

	assign bus_ready_o   = bus_valid_i && (addr_wait == 0);
	assign bus_data_ok_o = have_data && (data_wait == 0);
	assign bus_rdata_o   = mem[rd_addr[7:2]];

	// wait states of 0 to 3 cycles drawn per phase
	always @(posedge clk) begin
		if (!rst_n) begin
			if (!seeded) begin
				seeded = 1'b1;
				void'($urandom(SEED));
			end
			have_data <= 1'b0;
			addr_wait <= $urandom % 4;
		end else begin
			if (bus_valid_i && bus_ready_o) begin
				rd_addr   <= bus_addr_i;
				have_data <= 1'b1;
				data_wait <= $urandom % 4;
				addr_wait <= $urandom % 4;
			end else if (bus_valid_i && addr_wait != 0) begin
				addr_wait <= addr_wait - 1;
			end
			if (bus_data_ok_i && bus_data_ok_o) begin
				have_data <= 1'b0;
			end else if (have_data && data_wait != 0) begin
				data_wait <= data_wait - 1;
			end
		end
	end

endmodule

// File: test/tb_fetch_top.sv
`timescale 1ns/1ps

module tb_fetch_top;

	localparam int N_ROWS       = 8;
	localparam int RESET_CYCLES = 8;
	localparam int MAX_CYCLES   = RESET_CYCLES + 40 * N_ROWS;
	localparam logic [47:0] OP_LIST = {6'd14, 6'd50, 6'd3, 6'd6, 6'd43, 6'd35, 6'd9, 6'd0};

	logic                   clk;
	logic                   rst_n;
	fetch_pkg::addr_t       vpc_in;
	fetch_pkg::addr_t       ppc_in;
	fetch_pkg::slot_mask_t  mask_in;
	fetch_pkg::attached_t   attached_in;
	logic                   stall;
	logic                   clr;
	logic                   busy;
	fetch_pkg::addr_t       vpc_out;
	fetch_pkg::addr_t       ppc_out;
	fetch_pkg::slot_mask_t  valid_out;
	fetch_pkg::attached_t   attached_out;
	fetch_pkg::inst_class_e cls_out [fetch_pkg::FETCH_SIZE];
	fetch_pkg::reg_idx_t    rs_out [fetch_pkg::FETCH_SIZE];
	fetch_pkg::reg_idx_t    rt_out [fetch_pkg::FETCH_SIZE];
	fetch_pkg::reg_idx_t    rd_out [fetch_pkg::FETCH_SIZE];
	fetch_pkg::imm_t        imm_out [fetch_pkg::FETCH_SIZE];
	logic                   bus_valid;
	fetch_pkg::addr_t       bus_addr;
	logic                   bus_data_ok_m;
	logic                   bus_ready;
	fetch_pkg::word_t       bus_rdata;
	logic                   bus_data_ok_s;
	fetch_pkg::addr_t       addr_seen [$];
	int                     group_errors = 0;
	int                     slot_errors = 0;
	int                     bus_errors = 0;
	int                     ctrl_errors = 0;
	int                     cycle_count = 0;

	// one fetch group per row
	fetch_pkg::addr_t row_vpc [N_ROWS] = '{32'h0040_0000, 32'h0040_0008, 32'h0040_0010,
		32'h0040_0018, 32'h0040_0020, 32'h0040_0028, 32'h0040_0030, 32'h0040_0038};
	fetch_pkg::addr_t row_ppc [N_ROWS] = '{32'h20, 32'h48, 32'h54, 32'h70,
		32'h18, 32'h98, 32'hc0, 32'he0};
	fetch_pkg::slot_mask_t row_mask [N_ROWS] = '{2'b11, 2'b11, 2'b10, 2'b11,
		2'b11, 2'b11, 2'b00, 2'b01};
	fetch_pkg::attached_t row_att [N_ROWS] = '{32'ha5a5_0001, 32'h5a5a_0002, 32'h1234_0003,
		32'hcafe_0004, 32'hdead_0005, 32'hbeef_0006, 32'h0f0f_0007, 32'hf00d_0008};
	int row_stall [N_ROWS] = '{0, 0, 0, 4, 0, 0, 0, 0};
	bit row_clr [N_ROWS]   = '{0, 0, 0, 0, 1, 0, 0, 0};

	tb_clock_gen #(.HALF_PERIOD(10), .RESET_CYCLES(RESET_CYCLES)) clock_gen_i (
		.clk_o   (clk),
		.rst_n_o (rst_n)
	);

	tb_mem_responder mem_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.bus_valid_i   (bus_valid),
		.bus_addr_i    (bus_addr),
		.bus_data_ok_i (bus_data_ok_m),
		.bus_ready_o   (bus_ready),
		.bus_rdata_o   (bus_rdata),
		.bus_data_ok_o (bus_data_ok_s)
	);

	fetch_top fetch_top_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.vpc_i         (vpc_in),
		.ppc_i         (ppc_in),
		.valid_i       (mask_in),
		.attached_i    (attached_in),
		.stall_i       (stall),
		.clr_i         (clr),
		.busy_o        (busy),
		.vpc_o         (vpc_out),
		.ppc_o         (ppc_out),
		.valid_o       (valid_out),
		.attached_o    (attached_out),
		.class_o       (cls_out),
		.rs_o          (rs_out),
		.rt_o          (rt_out),
		.rd_o          (rd_out),
		.imm_o         (imm_out),
		.bus_valid_o   (bus_valid),
		.bus_addr_o    (bus_addr),
		.bus_data_ok_o (bus_data_ok_m),
		.bus_ready_i   (bus_ready),
		.bus_rdata_i   (bus_rdata),
		.bus_data_ok_i (bus_data_ok_s)
	);

	// address handshakes seen mid-cycle before the edge that takes them
	always @(negedge clk) begin
		if (rst_n && bus_valid && bus_ready) begin
			addr_seen.push_back(bus_addr);
		end
	end

	task automatic print_error_counts();
		$display("errors: group %0d, slot %0d, bus %0d, ctrl %0d", group_errors, slot_errors,
			bus_errors, ctrl_errors);
	endtask

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > MAX_CYCLES) begin
			$display("timeout after %0d cycles, a group never completed", cycle_count);
			print_error_counts();
			$display("sim failed");
			$finish;
		end
	end

	function automatic fetch_pkg::word_t word_at(input fetch_pkg::addr_t a);
		logic [31:0] mix;
		mix = (a ^ 32'h1f3a5c27) * 32'd40503;
		return {OP_LIST[a[4:2] * 6 +: 6], mix[25:0]};
	endfunction

	function automatic fetch_pkg::inst_class_e class_of(input logic [5:0] op);
		if (op == 6'd0) return fetch_pkg::ALU_REG;
		if (op >= 6'd8 && op <= 6'd15) return fetch_pkg::ALU_IMM;
		if (op == 6'd35) return fetch_pkg::LOAD;
		if (op == 6'd43) return fetch_pkg::STORE;
		if (op >= 6'd4 && op <= 6'd7) return fetch_pkg::BRANCH;
		if (op == 6'd2 || op == 6'd3) return fetch_pkg::JUMP;
		return fetch_pkg::ILLEGAL;
	endfunction

	// word address of slot s inside the aligned group that holds ppc
	function automatic fetch_pkg::addr_t slot_addr(input fetch_pkg::addr_t ppc, input int s);
		fetch_pkg::addr_t group_base;
		group_base = ppc & ~((32'd1 << (fetch_pkg::SLOT_W + 2)) - 32'd1);
		return group_base + fetch_pkg::addr_t'(4 * s);
	endfunction

	function automatic int note_mismatch(input string what, input logic [31:0] got, exp);
		$display("mismatch at %0t: %s = %h, expected %h", $time, what, got, exp);
		return 1;
	endfunction

	task automatic check_group(
		input fetch_pkg::addr_t      vpc, exp_vpc,
		input fetch_pkg::addr_t      ppc, exp_ppc,
		input fetch_pkg::slot_mask_t valid, exp_valid,
		input fetch_pkg::attached_t  att, exp_att
	);
		if (vpc !== exp_vpc) group_errors += note_mismatch("vpc_o", vpc, exp_vpc);
		if (ppc !== exp_ppc) group_errors += note_mismatch("ppc_o", ppc, exp_ppc);
		if (valid !== exp_valid) group_errors += note_mismatch("valid_o", valid, exp_valid);
		if (att !== exp_att) group_errors += note_mismatch("attached_o", att, exp_att);
	endtask

	task automatic check_slot(
		input int                     s,
		input fetch_pkg::inst_class_e cls, exp_cls,
		input fetch_pkg::reg_idx_t    rs, exp_rs, rt, exp_rt, rd, exp_rd,
		input fetch_pkg::imm_t        imm, exp_imm
	);
		if (cls !== exp_cls) begin
			slot_errors += note_mismatch($sformatf("class_o[%0d]", s), cls, exp_cls);
		end
		if (rs !== exp_rs) begin
			slot_errors += note_mismatch($sformatf("rs_o[%0d]", s), rs, exp_rs);
		end
		if (rt !== exp_rt) begin
			slot_errors += note_mismatch($sformatf("rt_o[%0d]", s), rt, exp_rt);
		end
		if (rd !== exp_rd) begin
			slot_errors += note_mismatch($sformatf("rd_o[%0d]", s), rd, exp_rd);
		end
		if (imm !== exp_imm) begin
			slot_errors += note_mismatch($sformatf("imm_o[%0d]", s), imm, exp_imm);
		end
	endtask

	task automatic check_ctrl(
		input logic busy_v, exp_busy,
		input logic bus_valid_v, exp_bus_valid,
		input logic data_ok_v, exp_data_ok
	);
		if (busy_v !== exp_busy) begin
			ctrl_errors += note_mismatch("busy_o", busy_v, exp_busy);
		end
		if (bus_valid_v !== exp_bus_valid) begin
			ctrl_errors += note_mismatch("bus_valid_o", bus_valid_v, exp_bus_valid);
		end
		if (data_ok_v !== exp_data_ok) begin
			ctrl_errors += note_mismatch("bus_data_ok_o", data_ok_v, exp_data_ok);
		end
	endtask

	task automatic check_decodes(input int r);
		fetch_pkg::word_t w;
		for (int s = 0; s < fetch_pkg::FETCH_SIZE; s++) begin
			if (row_mask[r][s]) begin
				w = word_at(slot_addr(row_ppc[r], s));
				check_slot(s, cls_out[s], class_of(w[31:26]), rs_out[s], w[25:21],
					rt_out[s], w[20:16], rd_out[s], w[15:11], imm_out[s], w[15:0]);
			end
		end
	endtask

	task automatic check_outputs(input int r);
		check_group(vpc_out, row_vpc[r], ppc_out, row_ppc[r], valid_out, row_mask[r],
			attached_out, row_att[r]);
		check_decodes(r);
	endtask

	// everything idle and zero right after reset
	task automatic check_reset_state();
		check_ctrl(busy, 1'b0, bus_valid, 1'b0, bus_data_ok_m, 1'b0);
		check_group(vpc_out, '0, ppc_out, '0, valid_out, '0, attached_out, '0);
		for (int s = 0; s < fetch_pkg::FETCH_SIZE; s++) begin
			check_slot(s, cls_out[s], fetch_pkg::ALU_REG, rs_out[s], '0, rt_out[s], '0,
				rd_out[s], '0, imm_out[s], '0);
		end
	endtask

	// addresses come lowest slot first and one per fetched slot
	task automatic check_bus_addrs(input int r, input int n);
		int idx;
		if (addr_seen.size() != n) begin
			bus_errors += note_mismatch("bus address count", addr_seen.size(), n);
		end
		idx = 0;
		for (int s = 0; s < fetch_pkg::FETCH_SIZE; s++) begin
			if (row_mask[r][s] && idx < n && idx < addr_seen.size()) begin
				if (addr_seen[idx] !== slot_addr(row_ppc[r], s)) begin
					bus_errors += note_mismatch("bus_addr_o", addr_seen[idx],
						slot_addr(row_ppc[r], s));
				end
				idx++;
			end
		end
		addr_seen.delete();
	endtask

	task automatic run_row(input int r);
		@(posedge clk);
		vpc_in      <= row_vpc[r];
		ppc_in      <= row_ppc[r];
		mask_in     <= row_mask[r];
		attached_in <= row_att[r];
		@(posedge clk);
		vpc_in      <= '0;
		ppc_in      <= '0;
		mask_in     <= '0;
		attached_in <= '0;
		// group enters stage 2 on this edge
		@(posedge clk);
		if (row_clr[r]) begin
			@(posedge clk);
			clr <= 1'b1;
			@(posedge clk);
			clr <= 1'b0;
			do begin
				@(negedge clk);
				if (valid_out != '0) group_errors += note_mismatch("valid_o", valid_out, 0);
			end while (busy || bus_valid || bus_data_ok_m);
			check_bus_addrs(r, 1);
			// the orphaned word never reaches a decoder
			if (r > 0) begin
				check_decodes(r - 1);
			end
		end else if (row_mask[r] == '0) begin
			@(negedge clk);
			check_outputs(r);
			check_ctrl(busy, 1'b0, bus_valid, 1'b0, bus_data_ok_m, 1'b0);
			repeat (2) begin
				@(negedge clk);
				check_ctrl(busy, 1'b0, bus_valid, 1'b0, bus_data_ok_m, 1'b0);
			end
			check_bus_addrs(r, 0);
		end else begin
			if (row_stall[r] > 0) begin
				@(posedge clk);
				stall <= 1'b1;
			end
			do begin
				@(negedge clk);
			end while (busy || valid_out == '0);
			check_outputs(r);
			repeat (row_stall[r]) begin
				@(negedge clk);
				check_outputs(r);
			end
			if (row_stall[r] > 0) begin
				@(posedge clk);
				stall <= 1'b0;
			end
			check_bus_addrs(r, $countones(row_mask[r]));
		end
	endtask

	initial begin
		vpc_in      = '0;
		ppc_in      = '0;
		mask_in     = '0;
		attached_in = '0;
		stall       = 1'b0;
		clr         = 1'b0;
		@(posedge rst_n);
		@(negedge clk);
		check_reset_state();
		@(posedge clk);
		for (int r = 0; r < N_ROWS; r++) begin
			run_row(r);
		end
		print_error_counts();
		if (group_errors == 0 && slot_errors == 0 && bus_errors == 0 && ctrl_errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

// File: build.f
source/fetch_pkg.sv
source/slot_decoder.sv
source/fetch_pipe.sv
source/fetch_bus_ctrl.sv
source/fetch_top.sv
test/tb_clock_gen.sv
test/tb_mem_responder.sv
test/tb_fetch_top.sv

// File: Bender.yml
package:
  name: fetch_frontend

sources:
  - files:
      - source/fetch_pkg.sv
      - source/slot_decoder.sv
      - source/fetch_pipe.sv
      - source/fetch_bus_ctrl.sv
      - source/fetch_top.sv
  - target: test
    files:
      - test/tb_clock_gen.sv
      - test/tb_mem_responder.sv
      - test/tb_fetch_top.sv
